/* Makefile */
TB_TOP = char_buffer_tb

.PHONY: all run lint clean

all: run

obj_dir/V$(TB_TOP): compile.f common/char_buffer_defs.svh common/char_buffer_pkg.sv \
		console_writer/char_decode.sv console_writer/cursor_ctrl.sv \
		source/char_ram.sv source/frame_reader.sv source/char_buffer_top.sv \
		verif/char_buffer_tb.sv
	verilator --binary --timing --assert -Wno-fatal -f compile.f --top-module $(TB_TOP)

# Pass only when the log holds the pass line
run: obj_dir/V$(TB_TOP)
	./obj_dir/V$(TB_TOP) > sim.log 2>&1; cat sim.log
	grep -q "PASS: all tests" sim.log

lint:
	verilator --lint-only --timing -Wall -f compile.f --top-module char_buffer_top

clean:
	rm -rf obj_dir sim.log

/* common/char_buffer_defs.svh */
// Grid geometry, font height and control-code values for the console character buffer
// Included by the package and by every module that sizes against the grid

`ifndef CHAR_BUFFER_DEFS_SVH
`define CHAR_BUFFER_DEFS_SVH

// Text grid
`define CB_COLS         16
`define CB_ROWS         8
`define CB_CELLS        (`CB_COLS * `CB_ROWS)
`define CB_ADDR_W       7

// Scan lines drawn per text row
`define CB_FONT_HEIGHT  4

// Code stored in an empty cell
`define CB_BLANK        8'h00

// Control codes with a meaning in the console
`define CB_BS           8'h08
`define CB_HT           8'h09
`define CB_LF           8'h0A
`define CB_CR           8'h0D
`define CB_DEL          8'h7F

`endif

/* common/char_buffer_pkg.sv */
// Types shared by the console character buffer blocks
// Imported by wildcard in each module header

`default_nettype none

`include "char_buffer_defs.svh"

package char_buffer_pkg;

  // Field widths of a frame beat
  localparam int COL_W  = $clog2(`CB_COLS);
  localparam int ROW_W  = $clog2(`CB_ROWS);
  localparam int LINE_W = $clog2(`CB_FONT_HEIGHT);

  typedef logic [`CB_ADDR_W-1:0] cell_addr_t;

  typedef enum logic [2:0] {
    OP_PRINT,
    OP_NEWLINE,
    OP_TAB,
    OP_BACKSPACE
  } char_op_e;

  // Decoded command, 11 bits
  typedef struct packed {
    char_op_e   op;
    logic [7:0] code;
  } char_cmd_t;

  // One frame beat, 17 bits
  typedef struct packed {
    logic [7:0]        code;
    logic [ROW_W-1:0]  text_row;
    logic [LINE_W-1:0] font_line;
    logic [COL_W-1:0]  col;
  } frame_beat_t;

endpackage

`default_nettype wire

/* compile.f */
+incdir+common
common/char_buffer_pkg.sv
console_writer/char_decode.sv
console_writer/cursor_ctrl.sv
source/char_ram.sv
source/frame_reader.sv
source/char_buffer_top.sv
verif/char_buffer_tb.sv

/* console_writer/char_decode.sv */
// Input stage: classifies each incoming byte into a buffer command
// Holds one command with valid/ready on both sides, drops ignored control codes

`timescale 1ns/1ps
`default_nettype none

`include "char_buffer_defs.svh"

module char_decode
  import char_buffer_pkg::*;
(
  input  wire             clk,
  input  wire             rst,
  input  wire             i_char_valid,
  input  wire [7:0]       i_char,
  output logic            o_char_ready,
  output logic            o_cmd_valid,
  output char_cmd_t       o_cmd,
  input  wire             i_cmd_ready
);

  logic      live_q;       // Low through reset, holds off the sender
  logic      cmd_valid_q;
  char_cmd_t cmd_q;
  char_op_e  op;
  logic      ignore;
  logic      accept;

  always_comb begin
    op     = OP_PRINT;
    ignore = 1'b0;
    case (i_char)
      `CB_BS:        op = OP_BACKSPACE;
      `CB_HT:        op = OP_TAB;
      `CB_LF, `CB_CR: op = OP_NEWLINE;
      `CB_DEL:       ignore = 1'b1;
      default:       ignore = (i_char < 8'h20);  // Remaining C0 codes
    endcase
  end

  assign o_char_ready = live_q && (!cmd_valid_q || i_cmd_ready);
  assign accept       = i_char_valid && o_char_ready;
  assign o_cmd_valid  = cmd_valid_q;
  assign o_cmd        = cmd_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      live_q      <= 1'b0;
      cmd_valid_q <= 1'b0;
    end else begin
      live_q <= 1'b1;
      if (accept && !ignore) begin
        cmd_valid_q <= 1'b1;
      end else if (i_cmd_ready) begin
        cmd_valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept && !ignore) begin
      cmd_q.op   <= op;
      cmd_q.code <= i_char;
    end
  end

  // Held command must not change until cursor control takes it
  assert property (@(posedge clk) disable iff (rst)
    (o_cmd_valid && !i_cmd_ready) |=> (o_cmd_valid && $stable(o_cmd)));

endmodule

`default_nettype wire

/* console_writer/cursor_ctrl.sv */
// Executes decoded commands and screen clears against the character RAM
// Owns the cursor; stays idle while the frame reader holds its claim

`timescale 1ns/1ps
`default_nettype none

`include "char_buffer_defs.svh"

module cursor_ctrl
  import char_buffer_pkg::*;
(
  input  wire             clk,
  input  wire             rst,
  input  wire             i_cmd_valid,
  input  wire char_cmd_t  i_cmd,
  output logic            o_cmd_ready,
  input  wire [2:0]       i_tab_count,
  input  wire             i_clear_stb,
  input  wire             i_read_claim,
  output logic            o_wr_busy,
  output logic            o_wr_en,
  output cell_addr_t      o_wr_addr,
  output logic [7:0]      o_wr_data
);

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_PRINT,     // Single write, also used by backspace
    ST_NEWLINE,   // Blank fill to end of row
    ST_TAB,       // Blank fill for the latched count
    ST_CLEAR      // Blank fill of the whole grid
  } state_e;

  localparam logic [COL_W-1:0] COL_LAST  = COL_W'(`CB_COLS - 1);
  localparam cell_addr_t       CELL_LAST = cell_addr_t'(`CB_CELLS - 1);

  state_e           state_q;
  cell_addr_t       cursor_q;
  logic [7:0]       code_q;
  logic             advance_q;     // Print moves the cursor, backspace does not
  logic [2:0]       tab_cnt_q;
  logic             clear_pend_q;
  logic [COL_W-1:0] cur_col;
  logic             cmd_fire;

  assign cur_col     = cursor_q[COL_W-1:0];
  assign o_cmd_ready = (state_q == ST_IDLE) && !i_read_claim && !clear_pend_q;
  assign cmd_fire    = i_cmd_valid && o_cmd_ready;

  // Every non-idle state writes one cell per cycle at the cursor
  assign o_wr_busy = (state_q != ST_IDLE);
  assign o_wr_en   = (state_q != ST_IDLE);
  assign o_wr_addr = cursor_q;
  assign o_wr_data = (state_q == ST_PRINT) ? code_q : `CB_BLANK;

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q      <= ST_CLEAR;  // Blank the RAM after reset
      cursor_q     <= '0;
      advance_q    <= 1'b0;
      tab_cnt_q    <= '0;
      clear_pend_q <= 1'b0;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (clear_pend_q && !i_read_claim) begin
            clear_pend_q <= 1'b0;
            cursor_q     <= '0;
            state_q      <= ST_CLEAR;
          end else if (cmd_fire) begin
            case (i_cmd.op)
              OP_PRINT: begin
                advance_q <= 1'b1;
                state_q   <= ST_PRINT;
              end
              OP_NEWLINE: state_q <= ST_NEWLINE;
              OP_TAB: begin
                tab_cnt_q <= i_tab_count;
                if (i_tab_count != 3'd0) begin
                  state_q <= ST_TAB;
                end
              end
              OP_BACKSPACE: begin
                // Column 0 leaves the cursor where it is
                if (cur_col != '0) begin
                  cursor_q  <= cursor_q - 1'b1;
                  advance_q <= 1'b0;
                  state_q   <= ST_PRINT;
                end
              end
              default: ;
            endcase
          end
        end
        ST_PRINT: begin
          if (advance_q) begin
            cursor_q <= cursor_q + 1'b1;  // Wraps from last cell to 0
          end
          state_q <= ST_IDLE;
        end
        ST_NEWLINE: begin
          cursor_q <= cursor_q + 1'b1;
          if (cur_col == COL_LAST) begin
            state_q <= ST_IDLE;
          end
        end
        ST_TAB: begin
          cursor_q  <= cursor_q + 1'b1;
          tab_cnt_q <= tab_cnt_q - 1'b1;
          if (tab_cnt_q == 3'd1) begin
            state_q <= ST_IDLE;
          end
        end
        ST_CLEAR: begin
          cursor_q <= cursor_q + 1'b1;
          if (cursor_q == CELL_LAST) begin
            state_q <= ST_IDLE;  // Cursor lands on 0
          end
        end
        default: state_q <= ST_IDLE;
      endcase

      if (i_clear_stb) begin
        clear_pend_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (cmd_fire && (i_cmd.op == OP_PRINT)) begin
      code_q <= i_cmd.code;
    end else if (cmd_fire && (i_cmd.op == OP_BACKSPACE)) begin
      code_q <= `CB_BLANK;
    end
  end

  // A claimed RAM sees no new write from an idle writer
  assert property (@(posedge clk) disable iff (rst)
    ((state_q == ST_IDLE) && i_read_claim) |=> !o_wr_en);

endmodule

`default_nettype wire

/* source/char_buffer_top.sv */
// Top level of the console character buffer
// Byte stream in through the decoder, frame beats out through the reader

`timescale 1ns/1ps
`default_nettype none

module char_buffer_top
  import char_buffer_pkg::*;
(
  input  wire             clk,
  input  wire             rst,
  input  wire             i_char_valid,
  input  wire [7:0]       i_char,
  output logic            o_char_ready,
  input  wire [2:0]       i_tab_count,
  input  wire             i_clear_stb,
  input  wire             i_frame_stb,
  output logic            o_beat_valid,
  output frame_beat_t     o_beat,
  input  wire             i_beat_ready
);

  logic       cmd_valid;
  char_cmd_t  cmd;
  logic       cmd_ready;
  logic       wr_busy;
  logic       wr_en;
  cell_addr_t wr_addr;
  logic [7:0] wr_data;
  logic       read_claim;
  cell_addr_t rd_addr;
  logic [7:0] rd_data;

  char_decode u_decode (
    .clk          (clk),
    .rst          (rst),
    .i_char_valid (i_char_valid),
    .i_char       (i_char),
    .o_char_ready (o_char_ready),
    .o_cmd_valid  (cmd_valid),
    .o_cmd        (cmd),
    .i_cmd_ready  (cmd_ready)
  );

  cursor_ctrl u_cursor (
    .clk          (clk),
    .rst          (rst),
    .i_cmd_valid  (cmd_valid),
    .i_cmd        (cmd),
    .o_cmd_ready  (cmd_ready),
    .i_tab_count  (i_tab_count),
    .i_clear_stb  (i_clear_stb),
    .i_read_claim (read_claim),
    .o_wr_busy    (wr_busy),
    .o_wr_en      (wr_en),
    .o_wr_addr    (wr_addr),
    .o_wr_data    (wr_data)
  );

  char_ram u_ram (
    .clk       (clk),
    .i_wr_en   (wr_en),
    .i_wr_addr (wr_addr),
    .i_wr_data (wr_data),
    .i_rd_addr (rd_addr),
    .o_rd_data (rd_data)
  );

  frame_reader u_reader (
    .clk          (clk),
    .rst          (rst),
    .i_frame_stb  (i_frame_stb),
    .i_wr_busy    (wr_busy),
    .o_read_claim (read_claim),
    .o_rd_addr    (rd_addr),
    .i_rd_data    (rd_data),
    .o_beat_valid (o_beat_valid),
    .o_beat       (o_beat),
    .i_beat_ready (i_beat_ready)
  );

endmodule

`default_nettype wire

/* source/char_ram.sv */
// Character cell storage, one write port and one read port
// Read data is registered and appears the cycle after the address

`timescale 1ns/1ps
`default_nettype none

`include "char_buffer_defs.svh"

module char_ram
  import char_buffer_pkg::*;
(
  input  wire             clk,
  input  wire             i_wr_en,
  input  wire cell_addr_t i_wr_addr,
  input  wire [7:0]       i_wr_data,
  input  wire cell_addr_t i_rd_addr,
  output logic [7:0]      o_rd_data
);

  logic [7:0] mem [`CB_CELLS];  // Contents set by the clear after reset

  always_ff @(posedge clk) begin
    if (i_wr_en) begin
      mem[i_wr_addr] <= i_wr_data;
    end
    o_rd_data <= mem[i_rd_addr];
  end

endmodule

`default_nettype wire

/* source/frame_reader.sv */
// Scans the grid into a frame of beats for the font renderer
// Row outermost, then font line, then column; stalls on output back-pressure

`timescale 1ns/1ps
`default_nettype none

`include "char_buffer_defs.svh"

module frame_reader
  import char_buffer_pkg::*;
(
  input  wire             clk,
  input  wire             rst,
  input  wire             i_frame_stb,
  input  wire             i_wr_busy,
  output logic            o_read_claim,
  output cell_addr_t      o_rd_addr,
  input  wire [7:0]       i_rd_data,
  output logic            o_beat_valid,
  output frame_beat_t     o_beat,
  input  wire             i_beat_ready
);

  localparam logic [COL_W-1:0]  COL_LAST  = COL_W'(`CB_COLS - 1);
  localparam logic [ROW_W-1:0]  ROW_LAST  = ROW_W'(`CB_ROWS - 1);
  localparam logic [LINE_W-1:0] LINE_LAST = LINE_W'(`CB_FONT_HEIGHT - 1);

  logic              claim_q;
  logic              scan_done_q;  // All addresses of the frame issued
  logic              rd_pend_q;    // RAM output holds an unconsumed word
  logic [ROW_W-1:0]  row_q;
  logic [LINE_W-1:0] line_q;
  logic [COL_W-1:0]  col_q;
  logic [ROW_W-1:0]  pend_row_q;
  logic [LINE_W-1:0] pend_line_q;
  logic [COL_W-1:0]  pend_col_q;
  cell_addr_t        next_addr;
  cell_addr_t        last_addr_q;
  frame_beat_t       beat_q;
  logic              beat_valid_q;
  logic              do_load;
  logic              do_issue;
  logic              scan_last;
  logic              beat_last;

  assign next_addr = cell_addr_t'(row_q * `CB_COLS + col_q);
  assign scan_last = (row_q == ROW_LAST) && (line_q == LINE_LAST) && (col_q == COL_LAST);
  assign beat_last = (beat_q.text_row == ROW_LAST) && (beat_q.font_line == LINE_LAST)
                     && (beat_q.col == COL_LAST);

  assign do_load  = rd_pend_q && (!beat_valid_q || i_beat_ready);
  assign do_issue = claim_q && !i_wr_busy && !scan_done_q && (!rd_pend_q || do_load);

  // Re-present the last address while stalled so RAM data holds
  assign o_rd_addr    = do_issue ? next_addr : last_addr_q;
  assign o_read_claim = claim_q;
  assign o_beat_valid = beat_valid_q;
  assign o_beat       = beat_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      claim_q      <= 1'b0;
      scan_done_q  <= 1'b1;
      rd_pend_q    <= 1'b0;
      beat_valid_q <= 1'b0;
      row_q        <= '0;
      line_q       <= '0;
      col_q        <= '0;
    end else begin
      if (!claim_q) begin
        if (i_frame_stb) begin
          claim_q     <= 1'b1;
          scan_done_q <= 1'b0;
          row_q       <= '0;
          line_q      <= '0;
          col_q       <= '0;
        end
      end else if (beat_valid_q && i_beat_ready && beat_last) begin
        claim_q <= 1'b0;  // Released after the final transfer
      end

      if (do_issue) begin
        rd_pend_q <= 1'b1;
        if (scan_last) begin
          scan_done_q <= 1'b1;
        end
        if (col_q == COL_LAST) begin
          col_q <= '0;
          if (line_q == LINE_LAST) begin
            line_q <= '0;
            row_q  <= row_q + 1'b1;
          end else begin
            line_q <= line_q + 1'b1;  // Same text row again
          end
        end else begin
          col_q <= col_q + 1'b1;
        end
      end else if (do_load) begin
        rd_pend_q <= 1'b0;
      end

      if (do_load) begin
        beat_valid_q <= 1'b1;
      end else if (i_beat_ready) begin
        beat_valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (do_issue) begin
      last_addr_q <= next_addr;
      pend_row_q  <= row_q;
      pend_line_q <= line_q;
      pend_col_q  <= col_q;
    end
    if (do_load) begin
      beat_q.code      <= i_rd_data;
      beat_q.text_row  <= pend_row_q;
      beat_q.font_line <= pend_line_q;
      beat_q.col       <= pend_col_q;
    end
  end

  assert property (@(posedge clk) disable iff (rst)
    (o_beat_valid && !i_beat_ready) |=> (o_beat_valid && $stable(o_beat)));

  // Beats only come out of a claimed frame
  assert property (@(posedge clk) disable iff (rst)
    o_beat_valid |-> o_read_claim);

endmodule

`default_nettype wire

/* verif/char_buffer_tb.sv */
// Self-checking testbench for the console character buffer
// Drives bytes, clears and frame requests; checks every beat against a reference model

`timescale 1ns/1ps
`default_nettype none

`include "char_buffer_defs.svh"

module char_buffer_tb
  import char_buffer_pkg::*;
;

  localparam int FRAME_BEATS = `CB_ROWS * `CB_FONT_HEIGHT * `CB_COLS;
  localparam int N_WRAP      = 150;  // More than one full grid of prints
  localparam int N_MIXED     = 80;
  localparam int N_LATE      = 20;
  localparam int TOTAL_BYTES = N_WRAP + N_MIXED + N_LATE + 4;
  // Six frames at up to 4 cycles a beat, each byte up to a 16-cell fill, three clears
  localparam int TIMEOUT_CYCLES = 6 * FRAME_BEATS * 4 + TOTAL_BYTES * 24
                                  + 3 * `CB_CELLS * 2 + 400;

  logic        clk;
  logic        rst;
  logic        i_char_valid;
  logic [7:0]  i_char;
  logic        o_char_ready;
  logic [2:0]  i_tab_count;
  logic        i_clear_stb;
  logic        i_frame_stb;
  logic        o_beat_valid;
  frame_beat_t o_beat;
  logic        i_beat_ready;

  logic [7:0]  model_mem [`CB_CELLS];
  cell_addr_t  model_cur;
  logic [31:0] lfsr_q = 32'd81100;
  int          errors = 0;
  int          beats_checked = 0;
  int          beat_idx = 0;
  bit          frame_open = 1'b0;
  int          in_frame_accepts = 0;
  int          cycles = 0;

  char_buffer_top dut0 (
    .clk          (clk),
    .rst          (rst),
    .i_char_valid (i_char_valid),
    .i_char       (i_char),
    .o_char_ready (o_char_ready),
    .i_tab_count  (i_tab_count),
    .i_clear_stb  (i_clear_stb),
    .i_frame_stb  (i_frame_stb),
    .o_beat_valid (o_beat_valid),
    .o_beat       (o_beat),
    .i_beat_ready (i_beat_ready)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Galois LFSR, x^32 + x^22 + x^2 + x + 1
  function automatic logic lfsr_bit();
    logic lsb;
    lsb    = lfsr_q[0];
    lfsr_q = lfsr_q >> 1;
    if (lsb) begin
      lfsr_q = lfsr_q ^ 32'h8020_0003;
    end
    return lsb;
  endfunction

  function automatic logic [7:0] rand_bits(input int n);
    logic [7:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r = {r[6:0], lfsr_bit()};
    end
    return r;
  endfunction

  function automatic logic [7:0] rand_printable();
    return 8'h20 + 8'(rand_bits(8) % 95);  // 0x20 to 0x7E
  endfunction

  function automatic void clear_model();
    foreach (model_mem[i]) begin
      model_mem[i] = `CB_BLANK;
    end
    model_cur = '0;
  endfunction

  // Expected effect of one byte on the grid and cursor
  function automatic void apply_byte(input logic [7:0] b, input logic [2:0] tabs);
    int i;
    if (b == `CB_CR || b == `CB_LF) begin
      do begin
        model_mem[model_cur] = `CB_BLANK;
        model_cur = model_cur + 1'b1;
      end while (model_cur[3:0] != 4'd0);
    end else if (b == `CB_HT) begin
      for (i = 0; i < int'(tabs); i++) begin
        model_mem[model_cur] = `CB_BLANK;
        model_cur = model_cur + 1'b1;
      end
    end else if (b == `CB_BS) begin
      if (model_cur[3:0] != 4'd0) begin
        model_cur = model_cur - 1'b1;
        model_mem[model_cur] = `CB_BLANK;
      end
    end else if (b >= 8'h20 && b != `CB_DEL) begin
      model_mem[model_cur] = b;
      model_cur = model_cur + 1'b1;  // Wraps to cell 0
    end
  endfunction

  // Waits until the decoder register is empty or emptying
  task automatic wait_decoder_room();
    @(negedge clk);
    while (!o_char_ready) @(negedge clk);
    @(posedge clk);
  endtask

  // A tab waiting in the decoder latches i_tab_count only when it fires
  task automatic send_byte(input logic [7:0] b, input logic [2:0] tabs);
    wait_decoder_room();
    i_char_valid <= 1'b1;
    i_char       <= b;
    if (b == `CB_HT) begin
      i_tab_count <= tabs;
    end
    @(negedge clk);
    while (!o_char_ready) @(negedge clk);
    if (frame_open) begin
      in_frame_accepts++;
    end
    @(posedge clk);
    i_char_valid <= 1'b0;
  endtask

  task automatic read_frame(input bit random_ready);
    beat_idx   = 0;
    frame_open = 1'b1;
    @(posedge clk);
    i_frame_stb <= 1'b1;
    @(posedge clk);
    i_frame_stb <= 1'b0;
    while (beat_idx < FRAME_BEATS) begin
      @(posedge clk);
      i_beat_ready <= random_ready ? lfsr_bit() : 1'b1;
    end
    frame_open = 1'b0;
    i_beat_ready <= 1'b1;
    repeat (4) @(posedge clk);  // Room for a stray beat to show
  endtask

  task automatic report_test(input string name, input int errs_before);
    if (errors == errs_before) begin
      $display("%s: ok", name);
    end else begin
      $display("%s: %0d errors", name, errors - errs_before);
    end
  endtask

  // Compare process, one transfer per rising edge
  always @(negedge clk) begin : compare_beats
    logic [2:0] exp_row;
    logic [1:0] exp_line;
    logic [3:0] exp_col;
    logic [7:0] exp_code;
    if (!rst && o_beat_valid && (!frame_open || beat_idx >= FRAME_BEATS)) begin
      $display("beat valid while no frame beat is expected");
      errors++;
    end else if (!rst && o_beat_valid && i_beat_ready) begin
      exp_row  = 3'(beat_idx / (`CB_FONT_HEIGHT * `CB_COLS));
      exp_line = 2'((beat_idx / `CB_COLS) % `CB_FONT_HEIGHT);
      exp_col  = 4'(beat_idx % `CB_COLS);
      exp_code = model_mem[cell_addr_t'({exp_row, exp_col})];
      if (o_beat.text_row !== exp_row) begin
        $display("mismatch o_beat.text_row at beat %0d: got %h, expected %h",
                 beat_idx, o_beat.text_row, exp_row);
        errors++;
      end
      if (o_beat.font_line !== exp_line) begin
        $display("mismatch o_beat.font_line at beat %0d: got %h, expected %h",
                 beat_idx, o_beat.font_line, exp_line);
        errors++;
      end
      if (o_beat.col !== exp_col) begin
        $display("mismatch o_beat.col at beat %0d: got %h, expected %h",
                 beat_idx, o_beat.col, exp_col);
        errors++;
      end
      if (o_beat.code !== exp_code) begin
        $display("mismatch o_beat.code at beat %0d: got %h, expected %h",
                 beat_idx, o_beat.code, exp_code);
        errors++;
      end
      beat_idx++;
      beats_checked++;
    end
  end

  initial begin
    while (cycles < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout after %0d cycles, a frame or a byte never completed", cycles);
    $display("FAIL: see errors above");
    $finish;
  end

  initial begin : run_tests
    int         errs_before;
    logic [7:0] b;
    logic [2:0] tabs;
    logic [7:0] deferred [$];
    rst          <= 1'b1;
    i_char_valid <= 1'b0;
    i_char       <= 8'h00;
    i_tab_count  <= 3'd0;
    i_clear_stb  <= 1'b0;
    i_frame_stb  <= 1'b0;
    i_beat_ready <= 1'b1;
    clear_model();  // Reset clears the grid
    errs_before = errors;
    repeat (15) @(posedge clk);
    @(negedge clk);
    // Both handshake outputs stay low while reset is held
    if (o_char_ready !== 1'b0) begin
      $display("mismatch o_char_ready during reset: got %h, expected %h",
               o_char_ready, 1'b0);
      errors++;
    end
    if (o_beat_valid !== 1'b0) begin
      $display("mismatch o_beat_valid during reset: got %h, expected %h",
               o_beat_valid, 1'b0);
      errors++;
    end
    @(posedge clk);
    rst <= 1'b0;

    read_frame(1'b0);
    report_test("test 1 blank frame after reset", errs_before);

    errs_before = errors;
    for (int i = 0; i < N_WRAP; i++) begin
      b = rand_printable();
      send_byte(b, 3'd0);
      apply_byte(b, 3'd0);
    end
    wait_decoder_room();
    read_frame(1'b0);
    report_test("test 2 cursor wrap", errs_before);

    errs_before = errors;
    send_byte(`CB_LF, 3'd0);
    apply_byte(`CB_LF, 3'd0);
    send_byte(`CB_BS, 3'd0);  // At column 0
    apply_byte(`CB_BS, 3'd0);
    for (int i = 0; i < N_MIXED; i++) begin
      tabs = 3'd0;
      case (rand_bits(3))
        8'd0, 8'd1, 8'd2, 8'd3: b = rand_printable();
        8'd4: b = lfsr_bit() ? `CB_CR : `CB_LF;
        8'd5: begin
          b    = `CB_HT;
          tabs = 3'(rand_bits(3));
        end
        8'd6: b = `CB_BS;
        default: begin
          b = rand_bits(5);
          if (b == `CB_BS || b == `CB_HT || b == `CB_LF || b == `CB_CR) begin
            b = `CB_DEL;
          end
        end
      endcase
      send_byte(b, tabs);
      apply_byte(b, tabs);
    end
    wait_decoder_room();
    read_frame(1'b0);
    report_test("test 3 mixed control codes", errs_before);

    errs_before = errors;
    @(posedge clk);
    i_clear_stb <= 1'b1;
    @(posedge clk);
    i_clear_stb <= 1'b0;
    clear_model();
    repeat (20) @(posedge clk);  // Longest fill in flight is 16 cells
    read_frame(1'b0);
    send_byte(8'h41, 3'd0);
    apply_byte(8'h41, 3'd0);
    report_test("test 4 clear request", errs_before);

    // Frame 1 of this test also shows the print after the clear in cell 0
    errs_before = errors;
    wait_decoder_room();
    in_frame_accepts = 0;
    fork
      read_frame(1'b1);
      begin
        repeat (3) @(posedge clk);
        for (int i = 0; i < N_LATE; i++) begin
          b = rand_printable();
          send_byte(b, 3'd0);
          deferred.push_back(b);
        end
      end
    join
    if (in_frame_accepts > 1) begin
      $display("decoder took %0d bytes during a frame, at most one fits", in_frame_accepts);
      errors++;
    end
    foreach (deferred[i]) begin
      apply_byte(deferred[i], 3'd0);
    end
    wait_decoder_room();
    read_frame(1'b1);
    report_test("test 5 frame under back-pressure", errs_before);

    $display("tests: 5, beats checked: %0d, errors: %0d", beats_checked, errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

`default_nettype wire
